// File: include/mem_stage_defines.svh
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Cache geometry
`define MS_LINE_BITS 128
`define MS_LINES 8

// Translation
`define MS_TLB_ENTRIES 4
`define MS_PAGE_BITS 12

// Store buffer and ROB
`define MS_SB_DEPTH 4
`define MS_ROB_IDX_BITS 4

`endif

// File: hw/mem_stage_pkg.sv
`include "mem_stage_defines.svh"

package mem_stage_pkg;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } mem_op_e;

    // funct3 encodings
    typedef enum logic [2:0] {
        W_BYTE   = 3'b000,
        W_HALF   = 3'b001,
        W_WORD   = 3'b010,
        W_BYTE_U = 3'b100,
        W_HALF_U = 3'b101
    } mem_width_e;

    typedef enum logic [2:0] {
        EXC_NONE      = 3'd0,
        EXC_DTLB_MISS = 3'd1
    } exc_e;

    typedef enum logic [1:0] {
        CS_IDLE,
        CS_WRITEBACK,
        CS_REFILL
    } cache_state_e;

    typedef struct packed {
        mem_op_e                     op;
        mem_width_e                  width;
        logic [31:0]                 addr;
        logic [31:0]                 data;
        logic [`MS_ROB_IDX_BITS-1:0] rob_idx;
    } mem_req_t;

    typedef struct packed {
        logic                        valid;
        logic [`MS_ROB_IDX_BITS-1:0] idx;
        logic                        is_store;
        exc_e                        exception;
    } rob_commit_t;

    typedef struct packed {
        logic                         valid;
        logic [31-`MS_PAGE_BITS:0]    vpage;
        logic [31-`MS_PAGE_BITS:0]    ppage;
    } tlb_write_t;

    typedef struct packed {
        logic                        complete;
        logic [`MS_ROB_IDX_BITS-1:0] rob_idx;
        logic [31:0]                 read_data;
        exc_e                        exception;
    } mem_stage_resp_t;

    // Line aligned address
    typedef struct packed {
        logic                     read_en;
        logic                     write_en;
        logic [31:0]              addr;
        logic [`MS_LINE_BITS-1:0] write_data;
    } mem_bus_req_t;

    typedef struct packed {
        logic        read;
        logic        write;
        mem_width_e  width;
        logic [31:0] addr;
        logic [31:0] data;
    } cache_access_t;

    // Picks the addressed byte or half out of a word and extends it
    function automatic logic [31:0] load_extend(logic [31:0] word, mem_width_e width,
                                                logic [1:0] offset);
        logic [31:0] shifted;
        shifted = word >> {offset, 3'b000};
        case (width)
            W_BYTE:   load_extend = {{24{shifted[7]}}, shifted[7:0]};
            W_BYTE_U: load_extend = {24'b0, shifted[7:0]};
            W_HALF:   load_extend = {{16{shifted[15]}}, shifted[15:0]};
            W_HALF_U: load_extend = {16'b0, shifted[15:0]};
            default:  load_extend = word;
        endcase
    endfunction

endpackage

// File: hw/store_buffer.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module store_buffer (
    input  logic                         clk,
    input  logic                         reset,
    input  mem_stage_pkg::mem_req_t      req,
    input  logic                         accept,
    input  mem_stage_pkg::rob_commit_t   rob_commit,
    input  logic                         drain_grant,
    output mem_stage_pkg::cache_access_t drain,
    output logic                         drain_valid,
    output logic                         bypass_hit,
    output logic [31:0]                  bypass_data,
    output logic                         full_stall,
    output logic                         overlap_stall
);
    localparam int DEPTH = `MS_SB_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef struct packed {
        logic [31:0]                 addr;
        logic [31:0]                 data;
        mem_stage_pkg::mem_width_e   width;
        logic [`MS_ROB_IDX_BITS-1:0] rob_idx;
    } sb_entry_t;

    sb_entry_t        entries [DEPTH];
    logic [DEPTH-1:0] valid;
    logic [DEPTH-1:0] committed;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_committed;
    logic             is_load;
    logic             push;
    logic             commit_store;
    logic             flush;

    assign is_load = req.op == mem_stage_pkg::OP_LOAD;
    assign commit_store = rob_commit.valid && rob_commit.is_store
                          && rob_commit.exception == mem_stage_pkg::EXC_NONE;
    assign flush = rob_commit.valid && rob_commit.exception != mem_stage_pkg::EXC_NONE;
    // A flush also kills a store accepted in the same cycle
    assign push = accept && req.op == mem_stage_pkg::OP_STORE && !flush;
    assign full_stall = req.op == mem_stage_pkg::OP_STORE && count == CNT_W'(DEPTH);

    // Committed entries always sit at the head
    always_comb begin
        n_committed = '0;
        for (int i = 0; i < DEPTH; i++)
            n_committed = n_committed + CNT_W'(valid[i] & committed[i]);
    end

    // Load check, walked oldest to youngest so the youngest match wins
    always_comb begin
        logic [PTR_W-1:0] slot;
        logic [31:0]      word;
        logic             found;
        logic             partial;
        word = '0;
        found = 1'b0;
        partial = 1'b0;
        for (int k = 0; k < DEPTH; k++) begin
            slot = head + PTR_W'(k);
            if (valid[slot] && entries[slot].addr[31:2] == req.addr[31:2]) begin
                found = entries[slot].width == mem_stage_pkg::W_WORD;
                partial = !found;
                word = entries[slot].data;
            end
        end
        bypass_hit = is_load && found;
        overlap_stall = is_load && partial;
        bypass_data = mem_stage_pkg::load_extend(word, req.width, req.addr[1:0]);
    end

    assign drain_valid = valid[head] && committed[head];
    assign drain = '{read:  1'b0,
                     write: drain_valid,
                     width: entries[head].width,
                     addr:  entries[head].addr,
                     data:  entries[head].data};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            committed <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (commit_store && valid[i] && entries[i].rob_idx == rob_commit.idx)
                    committed[i] <= 1'b1;
            end
            if (drain_grant) begin
                valid[head] <= 1'b0;
                committed[head] <= 1'b0;
                head <= head + 1'b1;
            end
            if (flush) begin
                // Keep only the committed run behind the head
                for (int i = 0; i < DEPTH; i++) begin
                    if (!committed[i])
                        valid[i] <= 1'b0;
                end
                tail <= head + n_committed[PTR_W-1:0];
                count <= n_committed - CNT_W'(drain_grant);
            end else begin
                if (push) begin
                    valid[tail] <= 1'b1;
                    committed[tail] <= 1'b0;
                    tail <= tail + 1'b1;
                end
                count <= count + CNT_W'(push) - CNT_W'(drain_grant);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[tail] <= '{addr: req.addr, data: req.data, width: req.width,
                               rob_idx: req.rob_idx};
    end

    assert property (@(posedge clk) disable iff (reset) push |-> count != CNT_W'(DEPTH))
        else $error("store buffer enqueue while full");
    assert property (@(posedge clk) disable iff (reset) drain_grant |-> count != '0)
        else $error("store buffer drain while empty");

endmodule

// File: hw/dtlb.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module dtlb (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      supervisor,
    input  logic [31:0]               vaddr,
    input  mem_stage_pkg::tlb_write_t tlb_write,
    output logic [31:0]               paddr,
    output logic                      hit
);
    localparam int ENTRIES = `MS_TLB_ENTRIES;
    localparam int PAGE_W = 32 - `MS_PAGE_BITS;
    localparam int PTR_W = $clog2(ENTRIES);

    logic [ENTRIES-1:0] valid;
    logic [PAGE_W-1:0]  vpage [ENTRIES];
    logic [PAGE_W-1:0]  ppage [ENTRIES];
    logic [ENTRIES-1:0] match;
    logic [PAGE_W-1:0]  ppage_sel;
    logic [PTR_W-1:0]   rr_ptr;
    logic [PTR_W-1:0]   write_slot;
    logic               write_found;

    always_comb begin
        ppage_sel = '0;
        write_slot = rr_ptr;
        write_found = 1'b0;
        for (int i = 0; i < ENTRIES; i++) begin
            match[i] = valid[i] && vpage[i] == vaddr[31:`MS_PAGE_BITS];
            if (match[i])
                ppage_sel = ppage_sel | ppage[i];
            // Rewrite of an existing page reuses its slot
            if (valid[i] && vpage[i] == tlb_write.vpage) begin
                write_slot = PTR_W'(i);
                write_found = 1'b1;
            end
        end
    end

    // Supervisor accesses are identity mapped
    assign hit = supervisor || |match;
    assign paddr = supervisor ? vaddr : {ppage_sel, vaddr[`MS_PAGE_BITS-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            rr_ptr <= '0;
        end else if (tlb_write.valid) begin
            valid[write_slot] <= 1'b1;
            if (!write_found)
                rr_ptr <= rr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_write.valid) begin
            vpage[write_slot] <= tlb_write.vpage;
            ppage[write_slot] <= tlb_write.ppage;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(match))
        else $error("dtlb multiple entries match");

endmodule

// File: hw/data_cache.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module data_cache (
    input  logic                         clk,
    input  logic                         reset,
    input  mem_stage_pkg::cache_access_t access,
    input  logic                         tlb_hit,
    output logic [31:0]                  read_data,
    output logic                         busy,
    output mem_stage_pkg::mem_bus_req_t  mem_bus,
    input  logic [`MS_LINE_BITS-1:0]     mem_read_data,
    input  logic                         mem_ready
);
    localparam int LINES = `MS_LINES;
    localparam int OFF_W = $clog2(`MS_LINE_BITS / 8);
    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = 32 - OFF_W - IDX_W;

    mem_stage_pkg::cache_state_e state;
    logic [LINES-1:0]         valid;
    logic [LINES-1:0]         dirty;
    logic [TAG_W-1:0]         tags [LINES];
    logic [`MS_LINE_BITS-1:0] lines [LINES];
    logic [IDX_W-1:0]         idx;
    logic [IDX_W-1:0]         miss_idx;
    logic [TAG_W-1:0]         tag;
    logic [TAG_W-1:0]         miss_tag;
    logic [OFF_W-3:0]         word_sel;
    logic                     active;
    logic                     line_hit;
    logic                     miss;
    logic [31:0]              cur_word;
    logic [31:0]              merged_word;

    assign idx = access.addr[OFF_W +: IDX_W];
    assign tag = access.addr[31 -: TAG_W];
    assign word_sel = access.addr[OFF_W-1:2];
    // Untranslated accesses are dropped here
    assign active = (access.read || access.write) && tlb_hit;
    assign line_hit = valid[idx] && tags[idx] == tag;
    assign miss = active && !line_hit && state == mem_stage_pkg::CS_IDLE;
    assign busy = state != mem_stage_pkg::CS_IDLE || miss;

    assign cur_word = lines[idx][{word_sel, 5'b00000} +: 32];
    assign read_data = mem_stage_pkg::load_extend(cur_word, access.width, access.addr[1:0]);

    // Byte lane merge for sub-word stores
    always_comb begin
        logic [3:0]  mask;
        logic [31:0] wdata;
        case (access.width)
            mem_stage_pkg::W_BYTE, mem_stage_pkg::W_BYTE_U: begin
                mask = 4'b0001 << access.addr[1:0];
                wdata = {4{access.data[7:0]}};
            end
            mem_stage_pkg::W_HALF, mem_stage_pkg::W_HALF_U: begin
                mask = 4'b0011 << access.addr[1:0];
                wdata = {2{access.data[15:0]}};
            end
            default: begin
                mask = 4'b1111;
                wdata = access.data;
            end
        endcase
        for (int b = 0; b < 4; b++)
            merged_word[8*b +: 8] = mask[b] ? wdata[8*b +: 8] : cur_word[8*b +: 8];
    end

    // Bus request held steady by the FSM state alone
    always_comb begin
        mem_bus = '0;
        case (state)
            mem_stage_pkg::CS_WRITEBACK: begin
                mem_bus.write_en = 1'b1;
                mem_bus.addr = {tags[miss_idx], miss_idx, {OFF_W{1'b0}}};
                mem_bus.write_data = lines[miss_idx];
            end
            mem_stage_pkg::CS_REFILL: begin
                mem_bus.read_en = 1'b1;
                mem_bus.addr = {miss_tag, miss_idx, {OFF_W{1'b0}}};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mem_stage_pkg::CS_IDLE;
            valid <= '0;
            dirty <= '0;
        end else begin
            case (state)
                mem_stage_pkg::CS_IDLE: begin
                    if (miss)
                        state <= (valid[idx] && dirty[idx]) ? mem_stage_pkg::CS_WRITEBACK
                                                            : mem_stage_pkg::CS_REFILL;
                    else if (active && access.write)
                        dirty[idx] <= 1'b1;
                end
                mem_stage_pkg::CS_WRITEBACK: begin
                    if (mem_ready) begin
                        dirty[miss_idx] <= 1'b0;
                        state <= mem_stage_pkg::CS_REFILL;
                    end
                end
                default: begin
                    if (mem_ready) begin
                        valid[miss_idx] <= 1'b1;
                        state <= mem_stage_pkg::CS_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            miss_idx <= idx;
            miss_tag <= tag;
        end
        if (state == mem_stage_pkg::CS_IDLE && active && line_hit && access.write)
            lines[idx][{word_sel, 5'b00000} +: 32] <= merged_word;
        if (state == mem_stage_pkg::CS_REFILL && mem_ready) begin
            lines[miss_idx] <= mem_read_data;
            tags[miss_idx] <= miss_tag;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(mem_bus.read_en && mem_bus.write_en))
        else $error("cache drives read and write together");
    assert property (@(posedge clk) disable iff (reset)
        (mem_bus.read_en || mem_bus.write_en) && !mem_ready |=> $stable(mem_bus))
        else $error("cache bus request changed before ready");

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  mem_stage_pkg::mem_req_t         req,
    input  mem_stage_pkg::rob_commit_t      rob_commit,
    input  logic                            supervisor,
    input  mem_stage_pkg::tlb_write_t       tlb_write,
    input  logic [`MS_LINE_BITS-1:0]        mem_read_data,
    input  logic                            mem_ready,
    output mem_stage_pkg::mem_stage_resp_t  resp,
    output logic                            stall,
    output mem_stage_pkg::mem_bus_req_t     mem_bus
);
    mem_stage_pkg::cache_access_t sb_drain;
    mem_stage_pkg::cache_access_t cache_acc;
    logic        load_req;
    logic        use_load;
    logic        accept;
    logic        drain_grant;
    logic        sb_drain_valid;
    logic        sb_bypass_hit;
    logic        sb_full;
    logic        sb_overlap;
    logic [31:0] sb_bypass_data;
    logic [31:0] cache_rd;
    logic [31:0] tlb_paddr;
    logic        tlb_hit;
    logic        cache_busy;

    assign load_req = req.op == mem_stage_pkg::OP_LOAD;
    // Loads own the cache port unless parked behind a partial store
    assign use_load = load_req && !sb_overlap;
    assign drain_grant = !use_load && sb_drain_valid && !cache_busy;
    assign stall = cache_busy || sb_full || sb_overlap;
    assign accept = req.op != mem_stage_pkg::OP_NONE && !stall;

    always_comb begin
        if (use_load) begin
            cache_acc = '{read:  !sb_bypass_hit,
                          write: 1'b0,
                          width: req.width,
                          addr:  tlb_paddr,
                          data:  req.data};
        end else begin
            cache_acc = sb_drain;
            cache_acc.write = sb_drain_valid;
            cache_acc.addr = tlb_paddr;
        end
    end

    // Store translation is checked when the entry drains
    always_comb begin
        resp.complete = accept;
        resp.rob_idx = req.rob_idx;
        resp.exception = (load_req && !sb_bypass_hit && !tlb_hit)
                         ? mem_stage_pkg::EXC_DTLB_MISS : mem_stage_pkg::EXC_NONE;
        resp.read_data = !load_req ? 32'b0 : sb_bypass_hit ? sb_bypass_data : cache_rd;
    end

    store_buffer sb0 (
        .clk(clk),
        .reset(reset),
        .req(req),
        .accept(accept),
        .rob_commit(rob_commit),
        .drain_grant(drain_grant),
        .drain(sb_drain),
        .drain_valid(sb_drain_valid),
        .bypass_hit(sb_bypass_hit),
        .bypass_data(sb_bypass_data),
        .full_stall(sb_full),
        .overlap_stall(sb_overlap)
    );

    dtlb dtlb0 (
        .clk(clk),
        .reset(reset),
        .supervisor(supervisor),
        .vaddr(use_load ? req.addr : sb_drain.addr),
        .tlb_write(tlb_write),
        .paddr(tlb_paddr),
        .hit(tlb_hit)
    );

    data_cache dcache0 (
        .clk(clk),
        .reset(reset),
        .access(cache_acc),
        .tlb_hit(tlb_hit),
        .read_data(cache_rd),
        .busy(cache_busy),
        .mem_bus(mem_bus),
        .mem_read_data(mem_read_data),
        .mem_ready(mem_ready)
    );

endmodule

// File: bench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
    parameter int HALF_PERIOD = 2
) (
    output logic clk
);
    initial clk = 1'b0;

    // 4 ns period
    always #HALF_PERIOD clk = ~clk;

endmodule

// File: bench/mem_stage_tb.sv
`timescale 1ns/1ns
`include "mem_stage_defines.svh"

module mem_stage_tb;
    logic                            clk;
    logic                            reset;
    mem_stage_pkg::mem_req_t         req;
    mem_stage_pkg::rob_commit_t      rob_commit;
    logic                            supervisor;
    mem_stage_pkg::tlb_write_t       tlb_write;
    logic [`MS_LINE_BITS-1:0]        mem_read_data;
    logic                            mem_ready;
    mem_stage_pkg::mem_stage_resp_t  resp;
    logic                            stall;
    mem_stage_pkg::mem_bus_req_t     mem_bus;

    // Reference state: flat byte memory plus stores not yet committed
    logic [7:0]                      ref_mem [logic [31:0]];
    bit                              touched [logic [31:0]];
    mem_stage_pkg::mem_req_t         pending [$];
    logic [`MS_LINE_BITS-1:0]        backing [logic [31:0]];
    mem_stage_pkg::mem_stage_resp_t  exp_q [$];
    bit                              chk_q [$];
    mem_stage_pkg::mem_stage_resp_t  exp_resp;
    bit                              chk_data;
    string                           current_test;
    logic [3:0]                      rob_next;
    int                              ops_issued;
    int                              completions;
    int                              cycles;
    int                              bus_count;
    int                              wait_cnt;
    integer                          seed;

    clock_gen clk_gen0 (.clk(clk));

    mem_stage dut0 (
        .clk(clk),
        .reset(reset),
        .req(req),
        .rob_commit(rob_commit),
        .supervisor(supervisor),
        .tlb_write(tlb_write),
        .mem_read_data(mem_read_data),
        .mem_ready(mem_ready),
        .resp(resp),
        .stall(stall),
        .mem_bus(mem_bus)
    );

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(string what, logic [31:0] expected, logic [31:0] actual);
        $display("[ERROR] %s %s: expected %h, actual %h", current_test, what, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    // Initial memory contents, a hash of every address bit
    function automatic logic [7:0] init_byte(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ {a[20:16], a[23:21]} ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [`MS_LINE_BITS-1:0] get_line(logic [31:0] line_addr);
        logic [`MS_LINE_BITS-1:0] line;
        if (backing.exists(line_addr))
            return backing[line_addr];
        for (int k = 0; k < `MS_LINE_BITS / 8; k++)
            line[8*k +: 8] = init_byte(line_addr + k);
        return line;
    endfunction

    function automatic logic [7:0] ref_byte(logic [31:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : init_byte(a);
    endfunction

    function automatic int width_bytes(mem_stage_pkg::mem_width_e w);
        case (w)
            mem_stage_pkg::W_BYTE, mem_stage_pkg::W_BYTE_U: return 1;
            mem_stage_pkg::W_HALF, mem_stage_pkg::W_HALF_U: return 2;
            default: return 4;
        endcase
    endfunction

    // Newest store to each byte wins, then extension by width
    function automatic logic [31:0] expected_load(logic [31:0] addr,
                                                  mem_stage_pkg::mem_width_e w);
        logic [7:0]  b [4];
        logic [31:0] a;
        int          o;
        for (int i = 0; i < 4; i++)
            b[i] = ref_byte({addr[31:2], 2'b00} + i);
        foreach (pending[p]) begin
            for (int j = 0; j < width_bytes(pending[p].width); j++) begin
                a = pending[p].addr + j;
                if (a[31:2] == addr[31:2])
                    b[a[1:0]] = pending[p].data[8*j +: 8];
            end
        end
        o = addr[1:0];
        case (w)
            mem_stage_pkg::W_BYTE:   return {{24{b[o][7]}}, b[o]};
            mem_stage_pkg::W_BYTE_U: return {24'b0, b[o]};
            mem_stage_pkg::W_HALF:   return {{16{b[o+1][7]}}, b[o+1], b[o]};
            mem_stage_pkg::W_HALF_U: return {16'b0, b[o+1], b[o]};
            default:                 return {b[3], b[2], b[1], b[0]};
        endcase
    endfunction

    // Drive one request and hold it until the DUT accepts it
    task automatic issue(mem_stage_pkg::mem_req_t r, mem_stage_pkg::mem_stage_resp_t e,
                         bit check_data);
        exp_q.push_back(e);
        chk_q.push_back(check_data);
        ops_issued++;
        @(posedge clk);
        req <= r;
        do @(negedge clk); while (!resp.complete);
        @(posedge clk);
        req <= '0;
    endtask

    task automatic issue_load(logic [31:0] vaddr, logic [31:0] paddr,
                              mem_stage_pkg::mem_width_e w, bit expect_miss);
        mem_stage_pkg::mem_req_t         r;
        mem_stage_pkg::mem_stage_resp_t  e;
        r = '{op: mem_stage_pkg::OP_LOAD, width: w, addr: vaddr, data: 32'h0,
              rob_idx: rob_next};
        e = '{complete: 1'b1, rob_idx: rob_next, read_data: expected_load(paddr, w),
              exception: expect_miss ? mem_stage_pkg::EXC_DTLB_MISS
                                     : mem_stage_pkg::EXC_NONE};
        rob_next++;
        issue(r, e, !expect_miss);
    endtask

    task automatic issue_store(logic [31:0] addr, mem_stage_pkg::mem_width_e w,
                               logic [31:0] data);
        mem_stage_pkg::mem_req_t         r;
        mem_stage_pkg::mem_stage_resp_t  e;
        r = '{op: mem_stage_pkg::OP_STORE, width: w, addr: addr, data: data,
              rob_idx: rob_next};
        e = '{complete: 1'b1, rob_idx: rob_next, read_data: 32'h0,
              exception: mem_stage_pkg::EXC_NONE};
        rob_next++;
        pending.push_back(r);
        for (int j = 0; j < width_bytes(w); j++)
            touched[addr + j] = 1'b1;
        issue(r, e, 1'b1);
    endtask

    task automatic commit_oldest();
        mem_stage_pkg::mem_req_t s;
        s = pending.pop_front();
        for (int j = 0; j < width_bytes(s.width); j++)
            ref_mem[s.addr + j] = s.data[8*j +: 8];
        @(posedge clk);
        rob_commit <= '{valid: 1'b1, idx: s.rob_idx, is_store: 1'b1,
                        exception: mem_stage_pkg::EXC_NONE};
        @(posedge clk);
        rob_commit <= '0;
    endtask

    task automatic flush_pending();
        pending.delete();
        @(posedge clk);
        rob_commit <= '{valid: 1'b1, idx: rob_next, is_store: 1'b0,
                        exception: mem_stage_pkg::EXC_DTLB_MISS};
        @(posedge clk);
        rob_commit <= '0;
    endtask

    // Backing memory with a random ready delay of 1 to 4 cycles
    always @(posedge clk) begin
        if (reset) begin
            mem_ready <= 1'b0;
            wait_cnt = 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;
        end else if (mem_bus.read_en || mem_bus.write_en) begin
            if (wait_cnt == 0)
                wait_cnt = 1 + ({$random(seed)} % 4);
            wait_cnt--;
            if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                bus_count++;
                if (mem_bus.write_en)
                    backing[mem_bus.addr] = mem_bus.write_data;
                else
                    mem_read_data <= get_line(mem_bus.addr);
            end
        end
    end

    // Compare every completion against the queued expectation
    always @(negedge clk) begin
        if (!reset && resp.complete) begin
            if (exp_q.size() == 0) begin
                fail_now("A response completed with no operation outstanding");
            end else begin
                exp_resp = exp_q.pop_front();
                chk_data = chk_q.pop_front();
                completions++;
                assert (resp.rob_idx == exp_resp.rob_idx)
                    else value_error("rob_idx", exp_resp.rob_idx, resp.rob_idx);
                assert (resp.exception == exp_resp.exception)
                    else value_error("exception", exp_resp.exception, resp.exception);
                assert (!chk_data || resp.read_data == exp_resp.read_data)
                    else value_error("read_data", exp_resp.read_data, resp.read_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * ops_issued + 200)
            fail_now("Timeout: the run exceeded its cycle limit");
    end

    initial begin
        mem_stage_pkg::mem_width_e widths [5];
        logic [31:0] a;
        int          traffic;
        logic [`MS_LINE_BITS-1:0] final_line;
        widths = '{mem_stage_pkg::W_BYTE, mem_stage_pkg::W_BYTE_U, mem_stage_pkg::W_HALF,
                   mem_stage_pkg::W_HALF_U, mem_stage_pkg::W_WORD};
        seed = 68;
        rob_next = '0;
        ops_issued = 0;
        completions = 0;
        cycles = 0;
        bus_count = 0;
        reset = 1'b1;
        req = '0;
        rob_commit = '0;
        supervisor = 1'b0;
        tlb_write = '0;
        mem_read_data = '0;
        mem_ready = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        current_test = "translation";
        traffic = bus_count;
        issue_load(32'h0004_0020, 32'h0004_0020, mem_stage_pkg::W_WORD, 1'b1);
        assert (bus_count == traffic)
            else fail_now("A TLB miss load caused memory traffic");
        @(posedge clk);
        tlb_write <= '{valid: 1'b1, vpage: 20'h00040, ppage: 20'h00005};
        @(posedge clk);
        tlb_write <= '0;
        issue_load(32'h0004_0020, 32'h0000_5020, mem_stage_pkg::W_WORD, 1'b0);
        issue_load(32'h0004_0026, 32'h0000_5026, mem_stage_pkg::W_HALF, 1'b0);
        @(posedge clk);
        supervisor <= 1'b1;

        current_test = "sub_word";
        issue_store(32'h2000, mem_stage_pkg::W_WORD, 32'h8bad_f00d);
        issue_store(32'h2006, mem_stage_pkg::W_HALF, 32'h0000_beef);
        issue_store(32'h2009, mem_stage_pkg::W_BYTE, 32'h0000_0080);
        issue_store(32'h200b, mem_stage_pkg::W_BYTE_U, 32'h0000_007f);
        repeat (4) commit_oldest();
        for (int wd = 0; wd < 3; wd++) begin
            foreach (widths[i]) begin
                for (int off = 0; off < 4; off += width_bytes(widths[i])) begin
                    a = 32'h2000 + 4 * wd + off;
                    issue_load(a, a, widths[i], 1'b0);
                end
            end
        end

        current_test = "bypass";
        issue_store(32'h3000, mem_stage_pkg::W_WORD, 32'hcafe_1234);
        issue_load(32'h3000, 32'h3000, mem_stage_pkg::W_WORD, 1'b0);
        issue_load(32'h3001, 32'h3001, mem_stage_pkg::W_BYTE, 1'b0);
        commit_oldest();
        issue_store(32'h3005, mem_stage_pkg::W_BYTE, 32'h0000_00a5);
        fork
            issue_load(32'h3004, 32'h3004, mem_stage_pkg::W_WORD, 1'b0);
            begin
                repeat (3) @(posedge clk);
                @(negedge clk);
                // The load must still be parked behind the uncommitted byte store
                assert (stall && completions == ops_issued - 1)
                    else fail_now("A load over a partial store completed before its commit");
                commit_oldest();
            end
        join

        current_test = "eviction";
        for (int k = 0; k < 4; k++)
            issue_store(32'h1000 + 32'h80 * k, mem_stage_pkg::W_WORD, 32'h1111_0000 + k);
        commit_oldest();
        issue_store(32'h1085, mem_stage_pkg::W_BYTE, 32'h0000_0033);
        repeat (4) commit_oldest();
        for (int k = 0; k < 4; k++) begin
            a = 32'h1000 + 32'h80 * k;
            issue_load(a, a, mem_stage_pkg::W_WORD, 1'b0);
            issue_load(a + 4, a + 4, mem_stage_pkg::W_WORD, 1'b0);
        end

        current_test = "flush";
        issue_store(32'h4000, mem_stage_pkg::W_WORD, 32'h0102_0304);
        commit_oldest();
        issue_store(32'h4000, mem_stage_pkg::W_WORD, 32'hdead_beef);
        issue_store(32'h4010, mem_stage_pkg::W_BYTE, 32'h0000_0055);
        flush_pending();
        issue_load(32'h4000, 32'h4000, mem_stage_pkg::W_WORD, 1'b0);
        issue_load(32'h4010, 32'h4010, mem_stage_pkg::W_BYTE_U, 1'b0);

        current_test = "back_pressure";
        for (int k = 0; k < 4; k++)
            issue_store(32'h5000 + 4 * k, mem_stage_pkg::W_WORD, 32'h5500_0000 + k);
        fork
            issue_store(32'h5010, mem_stage_pkg::W_WORD, 32'h5500_0004);
            begin
                repeat (6) @(posedge clk);
                @(negedge clk);
                // Fifth store held off while four uncommitted entries fill the buffer
                assert (stall && completions == ops_issued - 1)
                    else fail_now("The fifth store was accepted into a full store buffer");
                commit_oldest();
            end
        join
        repeat (4) commit_oldest();
        for (int k = 0; k < 5; k++)
            issue_load(32'h5000 + 4 * k, 32'h5000 + 4 * k, mem_stage_pkg::W_WORD, 1'b0);

        // Let the store buffer empty, then evict every line with conflicting loads
        current_test = "final_memory";
        while (dut0.sb_drain_valid)
            @(negedge clk);
        for (int i = 0; i < `MS_LINES; i++)
            issue_load(32'h7000 + 16 * i, 32'h7000 + 16 * i, mem_stage_pkg::W_WORD, 1'b0);
        foreach (touched[t]) begin
            a = t;
            final_line = get_line({a[31:4], 4'b0000});
            assert (final_line[8*a[3:0] +: 8] == ref_byte(a))
                else value_error("backing byte", ref_byte(a), final_line[8*a[3:0] +: 8]);
        end
        assert (completions == ops_issued)
            else fail_now("The number of completions differs from the operations issued");

        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Operations were left without a completion");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

// File: files.f
+incdir+include
hw/mem_stage_pkg.sv
hw/store_buffer.sv
hw/dtlb.sv
hw/data_cache.sv
hw/mem_stage.sv
bench/clock_gen.sv
bench/mem_stage_tb.sv
